//--- ex_core.f
rtl/pip_types.sv
rtl/shifter.sv
rtl/ex.sv
rtl/decode.sv
rtl/regfile.sv
rtl/ex_core.sv
verification/ex_core_tb.sv

//--- Bender.yml
package:
  name: ex_core

sources:
  - rtl/pip_types.sv
  - rtl/shifter.sv
  - rtl/ex.sv
  - rtl/decode.sv
  - rtl/regfile.sv
  - rtl/ex_core.sv
  - target: test
    files:
      - verification/ex_core_tb.sv

//--- verification/ex_core_tb.sv
`timescale 1ns/100ps

module ex_core_tb;

  import pip_types::*;

  localparam logic [31:0] k1      = 32'h12345678;
  localparam logic [31:0] k2      = 32'h80000000;
  localparam logic [31:0] k4      = 32'hffffff80;
  localparam logic [31:0] k5      = 32'hffffffff;
  localparam int          rnd_gap = -1; // Row gets 0 to 3 idle cycles.

  logic        clock;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        commit_valid;
  logic        commit_written;
  logic [4:0]  commit_reg;
  logic [31:0] commit_data;

  logic [31:0] instr_q [$];
  int          gap_q [$];
  logic        written_q [$];
  logic [4:0]  reg_q [$];
  logic [31:0] data_q [$];
  int          n_rows;
  int          got;
  int          value_errors;
  int          sequence_errors;
  logic        table_ready;

  ex_core dut (
    .clock          (clock),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .commit_valid   (commit_valid),
    .commit_written (commit_written),
    .commit_reg     (commit_reg),
    .commit_data    (commit_data)
  );

  function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sa);
    return {OPC_SPECIAL, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm16);
    return {op, rs, rt, imm16};
  endfunction

  function automatic logic [31:0] ext_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input int lsb, input int size);
    logic [4:0] msbd;
    logic [4:0] pos;
    msbd = size - 1;
    pos  = lsb;
    return {OPC_SPECIAL3, rs, rt, msbd, pos, FN_EXT};
  endfunction

  function automatic logic [31:0] ins_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input int lsb, input int size);
    logic [4:0] msb;
    logic [4:0] pos;
    msb = lsb + size - 1;
    pos = lsb;
    return {OPC_SPECIAL3, rs, rt, msb, pos, FN_INS};
  endfunction

  function automatic logic [31:0] bshfl_word(input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sa);
    return {OPC_SPECIAL3, 5'd0, rt, rd, sa, FN_BSHFL};
  endfunction

  function automatic logic [31:0] low_ones(input int size);
    if (size >= 32) return '1;
    return (32'h1 << size) - 32'h1;
  endfunction

  function automatic logic [31:0] extract_field(input logic [31:0] src, input int lsb,
                                                input int size);
    return (src >> lsb) & low_ones(size);
  endfunction

  function automatic logic [31:0] insert_field(input logic [31:0] dst, input logic [31:0] src,
                                               input int lsb, input int size);
    logic [31:0] m;
    m = low_ones(size) << lsb;
    return (dst & ~m) | ((src << lsb) & m);
  endfunction

  task automatic add_row(input logic [31:0] word, input int gap, input logic written,
                         input logic [4:0] dest, input logic [31:0] data);
    instr_q.push_back(word);
    gap_q.push_back(gap);
    written_q.push_back(written);
    reg_q.push_back(dest);
    data_q.push_back(data);
  endtask

  task automatic build_table();
    logic [31:0] acc;
    // Constants: r1 = k1, r2 = k2, r3 = 1, r4 = k4, r5 = k5.
    add_row(itype(OPC_LUI, 0, 1, 16'h1234), 0, 1, 1, 32'h12340000);
    add_row(itype(OPC_ORI, 1, 1, 16'h5678), 0, 1, 1, k1);
    add_row(itype(OPC_LUI, 0, 2, 16'h8000), 0, 1, 2, k2);
    add_row(itype(OPC_ORI, 0, 3, 16'h0001), rnd_gap, 1, 3, 32'h1);
    add_row(itype(OPC_LUI, 0, 4, 16'hffff), 0, 1, 4, 32'hffff0000);
    add_row(itype(OPC_ORI, 4, 4, 16'hff80), 0, 1, 4, k4);
    add_row(itype(OPC_ADDIU, 0, 5, 16'hffff), rnd_gap, 1, 5, k5);
    // Dependent chain, one strobe per cycle.
    acc = k1 + 32'h1;
    add_row(rtype(FN_ADDU, 1, 3, 6, 0), 0, 1, 6, acc);
    acc = acc - k2;
    add_row(rtype(FN_SUBU, 6, 2, 6, 0), 0, 1, 6, acc);
    acc = acc & k1;
    add_row(rtype(FN_AND, 6, 1, 7, 0), 0, 1, 7, acc);
    acc = acc | k2;
    add_row(rtype(FN_OR, 7, 2, 7, 0), 0, 1, 7, acc);
    acc = acc ^ k5;
    add_row(rtype(FN_XOR, 7, 5, 7, 0), 0, 1, 7, acc);
    acc = ~acc;
    add_row(rtype(FN_NOR, 7, 0, 8, 0), 0, 1, 8, acc);
    acc = acc + 32'd8;
    add_row(itype(OPC_ADDIU, 8, 8, 16'h0008), 0, 1, 8, acc);
    acc = acc ^ 32'h0000ffff;
    add_row(itype(OPC_XORI, 8, 8, 16'hffff), 0, 1, 8, acc);
    // Signed and unsigned compares.
    add_row(rtype(FN_SLT, 2, 3, 9, 0), rnd_gap, 1, 9, 32'h1);
    add_row(rtype(FN_SLTU, 2, 3, 9, 0), rnd_gap, 1, 9, 32'h0);
    add_row(rtype(FN_SLT, 3, 2, 10, 0), rnd_gap, 1, 10, 32'h0);
    add_row(rtype(FN_SLTU, 3, 2, 10, 0), rnd_gap, 1, 10, 32'h1);
    add_row(itype(OPC_SLTI, 5, 11, 16'h0000), rnd_gap, 1, 11, 32'h1);
    add_row(itype(OPC_SLTIU, 3, 11, 16'hffff), rnd_gap, 1, 11, 32'h1);
    add_row(itype(OPC_SLTIU, 5, 11, 16'hffff), rnd_gap, 1, 11, 32'h0);
    add_row(itype(OPC_SLTI, 3, 12, 16'h8000), rnd_gap, 1, 12, 32'h0);
    add_row(itype(OPC_SLTIU, 2, 12, 16'hffff), rnd_gap, 1, 12, 32'h1);
    // Shifts by 0, 1 and 31. Funct 0, 2, 3 fixed; 4, 6, 7 variable.
    add_row(rtype(6'h00, 0, 1, 13, 0), rnd_gap, 1, 13, k1);
    add_row(rtype(6'h00, 0, 1, 13, 1), rnd_gap, 1, 13, k1 << 1);
    add_row(rtype(6'h00, 0, 3, 13, 31), rnd_gap, 1, 13, 32'h80000000);
    add_row(rtype(6'h02, 0, 2, 14, 31), rnd_gap, 1, 14, 32'h1);
    add_row(rtype(6'h02, 0, 4, 14, 1), rnd_gap, 1, 14, 32'h7fffffc0);
    add_row(rtype(6'h02, 0, 1, 14, 0), rnd_gap, 1, 14, k1);
    add_row(rtype(6'h03, 0, 4, 14, 1), rnd_gap, 1, 14, 32'hffffffc0);
    add_row(rtype(6'h03, 0, 2, 14, 31), rnd_gap, 1, 14, 32'hffffffff);
    add_row(rtype(6'h03, 0, 1, 14, 0), rnd_gap, 1, 14, k1);
    add_row(rtype(6'h04, 3, 1, 15, 0), rnd_gap, 1, 15, k1 << 1);
    add_row(rtype(6'h04, 0, 1, 15, 0), rnd_gap, 1, 15, k1);
    add_row(rtype(6'h04, 5, 3, 15, 0), rnd_gap, 1, 15, 32'h80000000);
    add_row(rtype(6'h06, 5, 2, 15, 0), rnd_gap, 1, 15, 32'h1);
    add_row(rtype(6'h06, 0, 4, 15, 0), rnd_gap, 1, 15, k4);
    add_row(rtype(6'h07, 5, 2, 15, 0), rnd_gap, 1, 15, 32'hffffffff);
    add_row(rtype(6'h07, 3, 4, 15, 0), rnd_gap, 1, 15, 32'hffffffc0);
    add_row(rtype(6'h07, 0, 4, 15, 0), rnd_gap, 1, 15, k4);
    add_row(rtype(6'h06, 3, 4, 15, 0), rnd_gap, 1, 15, 32'h7fffffc0);
    // SEB is sa 0x10, SEH is sa 0x18.
    add_row(bshfl_word(4, 16, 5'h10), rnd_gap, 1, 16, 32'hffffff80);
    add_row(bshfl_word(4, 16, 5'h18), rnd_gap, 1, 16, 32'hffffff80);
    add_row(bshfl_word(8, 17, 5'h18), rnd_gap, 1, 17, 32'hffffa97f);
    add_row(bshfl_word(1, 17, 5'h10), rnd_gap, 1, 17, 32'h00000078);
    add_row(bshfl_word(1, 17, 5'h18), rnd_gap, 1, 17, 32'h00005678);
    // Bit fields.
    add_row(ext_word(1, 18, 4, 8), rnd_gap, 1, 18, extract_field(k1, 4, 8));
    add_row(ext_word(1, 18, 0, 32), rnd_gap, 1, 18, extract_field(k1, 0, 32));
    add_row(ext_word(2, 18, 31, 1), rnd_gap, 1, 18, extract_field(k2, 31, 1));
    add_row(ext_word(5, 18, 8, 12), rnd_gap, 1, 18, extract_field(k5, 8, 12));
    add_row(ext_word(4, 18, 7, 9), 0, 1, 18, extract_field(k4, 7, 9));
    acc = insert_field(32'h0, k1, 8, 8);
    add_row(ins_word(1, 19, 8, 8), 0, 1, 19, acc);
    acc = insert_field(acc, k5, 0, 4);
    add_row(ins_word(5, 19, 0, 4), 0, 1, 19, acc);
    acc = insert_field(acc, k5, 28, 4);
    add_row(ins_word(5, 19, 28, 4), 0, 1, 19, acc);
    acc = insert_field(acc, k1, 0, 32);
    add_row(ins_word(1, 19, 0, 32), 0, 1, 19, acc);
    acc = insert_field(acc, 32'h0, 12, 8);
    add_row(ins_word(0, 19, 12, 8), 0, 1, 19, acc);
    // Cancelled and dropped writes, then reads of the untouched registers.
    add_row(rtype(FN_MOVZ, 1, 0, 20, 0), 0, 1, 20, k1);
    add_row(rtype(FN_MOVZ, 2, 3, 20, 0), 0, 0, 20, k2);
    add_row(rtype(FN_ADDU, 20, 0, 22, 0), 0, 1, 22, k1);
    add_row(rtype(FN_MOVN, 2, 3, 21, 0), 0, 1, 21, k2);
    add_row(rtype(FN_MOVN, 1, 0, 21, 0), 0, 0, 21, k1);
    add_row(rtype(FN_ADDU, 21, 0, 22, 0), 0, 1, 22, k2);
    add_row(rtype(FN_ADDU, 1, 3, 0, 0), 0, 0, 0, k1 + 32'h1);
    add_row(itype(OPC_ORI, 0, 0, 16'h1234), 0, 0, 0, 32'h00001234);
    add_row(rtype(FN_ADDU, 0, 3, 23, 0), 0, 1, 23, 32'h1);
    add_row(rtype(6'h3f, 1, 3, 20, 0), 0, 0, 20, 32'h0);
    add_row(itype(6'h23, 1, 21, 16'ha800), 0, 0, 21, 32'h0); // rd field decodes to 21.
    add_row(rtype(FN_ADDU, 20, 21, 22, 0), 0, 1, 22, k1 + k2);
    add_row(rtype(FN_OR, 19, 18, 23, 0), rnd_gap, 1, 23, acc | extract_field(k4, 7, 9));
  endtask

  task automatic report_counts();
    $display("Result: %0d value errors, %0d sequence errors, %0d of %0d commits seen",
             value_errors, sequence_errors, got, n_rows);
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Commit checker, in table order.
  always @(negedge clock) begin
    if (arst_n && commit_valid) begin
      if (got >= n_rows) begin
        sequence_errors++;
        $display("Commit at %0t arrived after the last table row", $time);
      end else begin
        if (commit_written !== written_q[got]) begin
          value_errors++;
          $display("[FAIL] %0t row %0d commit_written: got %b expected %b",
                   $time, got, commit_written, written_q[got]);
        end
        if (commit_reg !== reg_q[got]) begin
          value_errors++;
          $display("[FAIL] %0t row %0d commit_reg: got %0d expected %0d",
                   $time, got, commit_reg, reg_q[got]);
        end
        if (commit_data !== data_q[got]) begin
          value_errors++;
          $display("[FAIL] %0t row %0d commit_data: got %h expected %h",
                   $time, got, commit_data, data_q[got]);
        end
        got++;
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (n_rows * 5 + 100) @(posedge clock);
    $display("Timeout waiting for commits");
    report_counts();
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int gap;
    arst_n          = 1'b0;
    instr_valid     = 1'b0;
    instr           = '0;
    got             = 0;
    value_errors    = 0;
    sequence_errors = 0;
    table_ready     = 1'b0;
    void'($urandom(32'h0b231d2b));
    build_table();
    n_rows      = instr_q.size();
    table_ready = 1'b1;
    repeat (8) @(posedge clock);
    arst_n <= 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clock);
      instr_valid <= 1'b1;
      instr       <= instr_q[i];
      gap = (gap_q[i] < 0) ? $urandom_range(3, 0) : gap_q[i];
      repeat (gap) begin
        @(posedge clock);
        instr_valid <= 1'b0;
      end
    end
    @(posedge clock);
    instr_valid <= 1'b0;
    wait (got == n_rows);
    repeat (4) @(posedge clock); // Catch stray commits.
    report_counts();
    if (value_errors == 0 && sequence_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- rtl/ex_core.sv
`timescale 1ns/100ps

module ex_core (
  input  logic                                  clock,
  input  logic                                  arst_n,
  input  logic                                  instr_valid,
  input  logic [31:0]                           instr,
  output logic                                  commit_valid,
  output logic                                  commit_written,
  output logic [pip_types::reg_addr_width-1:0]  commit_reg,
  output logic [pip_types::data_width-1:0]      commit_data
);

  import pip_types::*;

  logic [reg_addr_width-1:0]     ra_addr;
  logic [reg_addr_width-1:0]     rb_addr;
  logic [data_width-1:0]         ra_data;
  logic [data_width-1:0]         rb_data;
  logic                          ex_valid;
  logic                          ex_dest_valid;
  logic [reg_addr_width-1:0]     ex_dest_reg;
  logic [data_width-1:0]         a_val;
  logic [data_width-1:0]         b_val;
  logic [data_width-1:0]         imm;
  logic                          imm_valid;
  logic [$clog2(data_width)-1:0] shamt;
  logic                          shamt_valid;
  logic                          shleft;
  logic                          sharith;
  logic                          shopsela;
  alu_op_t                       alu_op;
  alu_res_t                      alu_res_sel;
  logic                          alu_set_u;
  logic [data_width-1:0]         result;
  logic                          inval_dest_reg;
  logic                          rf_we;

  assign rf_we = ex_valid && ex_dest_valid && !inval_dest_reg;

  decode u_decode (
    .clock         (clock),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .ra_addr       (ra_addr),
    .rb_addr       (rb_addr),
    .ra_data       (ra_data),
    .rb_data       (rb_data),
    .ex_result     (result),
    .ex_inval      (inval_dest_reg),
    .ex_valid      (ex_valid),
    .ex_dest_valid (ex_dest_valid),
    .ex_dest_reg   (ex_dest_reg),
    .a_val         (a_val),
    .b_val         (b_val),
    .imm           (imm),
    .imm_valid     (imm_valid),
    .shamt         (shamt),
    .shamt_valid   (shamt_valid),
    .shleft        (shleft),
    .sharith       (sharith),
    .shopsela      (shopsela),
    .alu_op        (alu_op),
    .alu_res_sel   (alu_res_sel),
    .alu_set_u     (alu_set_u)
  );

  regfile u_regfile (
    .clock   (clock),
    .arst_n  (arst_n),
    .ra_addr (ra_addr),
    .rb_addr (rb_addr),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .we      (rf_we),
    .wr_addr (ex_dest_reg),
    .wr_data (result)
  );

  ex u_ex (
    .a_val          (a_val),
    .b_val          (b_val),
    .imm            (imm),
    .imm_valid      (imm_valid),
    .shamt          (shamt),
    .shamt_valid    (shamt_valid),
    .shleft         (shleft),
    .sharith        (sharith),
    .shopsela       (shopsela),
    .alu_op         (alu_op),
    .alu_res_sel    (alu_res_sel),
    .alu_set_u      (alu_set_u),
    .result         (result),
    .inval_dest_reg (inval_dest_reg)
  );

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      commit_valid   <= 1'b0;
      commit_written <= 1'b0;
    end else begin
      commit_valid   <= ex_valid;
      commit_written <= rf_we;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      commit_reg  <= ex_dest_reg;
      commit_data <= result;
    end
  end

  // Fixed two-edge latency from strobe to commit.
  chk_latency: assert property (
    @(posedge clock) disable iff (!arst_n) instr_valid |-> ##2 commit_valid
  ) else $error("ex_core: strobe not committed two cycles later");

endmodule

//--- rtl/regfile.sv
`timescale 1ns/100ps

module regfile (
  input  logic                                  clock,
  input  logic                                  arst_n,
  input  logic [pip_types::reg_addr_width-1:0]  ra_addr,
  input  logic [pip_types::reg_addr_width-1:0]  rb_addr,
  output logic [pip_types::data_width-1:0]      ra_data,
  output logic [pip_types::data_width-1:0]      rb_data,
  input  logic                                  we,
  input  logic [pip_types::reg_addr_width-1:0]  wr_addr,
  input  logic [pip_types::data_width-1:0]      wr_data
);

  import pip_types::*;

  logic [data_width-1:0] regs [1:2**reg_addr_width-1]; // No storage for r0.

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
  assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

  // Decode drops r0 as a destination, so no write should target it.
  chk_no_r0_write: assert property (
    @(posedge clock) disable iff (!arst_n) !(we && wr_addr == '0)
  ) else $error("regfile: write enable with register 0 as target");

endmodule

//--- rtl/decode.sv
`timescale 1ns/100ps

module decode (
  input  logic                                      clock,
  input  logic                                      arst_n,
  input  logic                                      instr_valid,
  input  logic [31:0]                               instr,
  output logic [pip_types::reg_addr_width-1:0]      ra_addr,
  output logic [pip_types::reg_addr_width-1:0]      rb_addr,
  input  logic [pip_types::data_width-1:0]          ra_data,
  input  logic [pip_types::data_width-1:0]          rb_data,
  input  logic [pip_types::data_width-1:0]          ex_result,
  input  logic                                      ex_inval,
  output logic                                      ex_valid,
  output logic                                      ex_dest_valid,
  output logic [pip_types::reg_addr_width-1:0]      ex_dest_reg,
  output logic [pip_types::data_width-1:0]          a_val,
  output logic [pip_types::data_width-1:0]          b_val,
  output logic [pip_types::data_width-1:0]          imm,
  output logic                                      imm_valid,
  output logic [$clog2(pip_types::data_width)-1:0]  shamt,
  output logic                                      shamt_valid,
  output logic                                      shleft,
  output logic                                      sharith,
  output logic                                      shopsela,
  output pip_types::alu_op_t                        alu_op,
  output pip_types::alu_res_t                       alu_res_sel,
  output logic                                      alu_set_u
);

  import pip_types::*;

  opcode_t                   opcode;
  funct_t                    funct;
  logic [reg_addr_width-1:0] rs;
  logic [reg_addr_width-1:0] rt;
  logic [reg_addr_width-1:0] rd;
  logic [4:0]                sa;
  logic [15:0]               imm16;
  logic                      fwd_ok;
  logic [data_width-1:0]     a_fwd;
  logic [data_width-1:0]     b_fwd;
  logic                      legal;
  logic [reg_addr_width-1:0] d_dest_reg;
  logic [data_width-1:0]     d_imm;
  logic                      d_imm_valid;
  logic                      d_shamt_valid;
  logic                      d_shleft;
  logic                      d_sharith;
  logic                      d_shopsela;
  alu_op_t                   d_alu_op;
  alu_res_t                  d_alu_res_sel;
  logic                      d_alu_set_u;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign sa     = instr[10:6];
  assign imm16  = instr[15:0];

  assign ra_addr = rs;
  assign rb_addr = rt;

  // Bypass the result of the instruction now in ex.
  assign fwd_ok = ex_valid && ex_dest_valid && !ex_inval;
  assign a_fwd  = (fwd_ok && rs == ex_dest_reg) ? ex_result : ra_data;
  assign b_fwd  = (fwd_ok && rt == ex_dest_reg) ? ex_result : rb_data;

  always_comb begin
    legal         = 1'b1;
    d_dest_reg    = rd;
    d_imm         = {{(data_width-16){imm16[15]}}, imm16};
    d_imm_valid   = 1'b0;
    d_shamt_valid = 1'b1;
    d_shleft      = 1'b0;
    d_sharith     = 1'b0;
    d_shopsela    = 1'b0;
    d_alu_op      = OP_PASS_A;
    d_alu_res_sel = RES_ALU;
    d_alu_set_u   = 1'b0;
    case (opcode)
      OPC_SPECIAL: begin
        if (instr[5:3] == 3'b000) begin
          d_alu_res_sel = RES_SHIFT; // SLL, SRL, SRA and variable forms.
          d_shamt_valid = !instr[2];
          d_shleft      = (instr[1:0] == 2'b00);
          d_sharith     = (instr[1:0] == 2'b11);
          legal         = (instr[1:0] != 2'b01);
        end else begin
          case (funct)
            FN_ADDU: d_alu_op = OP_ADD;
            FN_SUBU: d_alu_op = OP_SUB;
            FN_AND:  d_alu_op = OP_AND;
            FN_OR:   d_alu_op = OP_OR;
            FN_XOR:  d_alu_op = OP_XOR;
            FN_NOR:  d_alu_op = OP_NOR;
            FN_MOVZ: d_alu_op = OP_MOVZ;
            FN_MOVN: d_alu_op = OP_MOVN;
            FN_SLT, FN_SLTU: begin
              d_alu_op      = OP_SUB;
              d_alu_res_sel = RES_SET;
              d_alu_set_u   = (funct == FN_SLTU);
            end
            default: legal = 1'b0;
          endcase
        end
      end
      OPC_ADDIU, OPC_SLTI, OPC_SLTIU: begin
        d_dest_reg    = rt;
        d_imm_valid   = 1'b1;
        d_alu_op      = (opcode == OPC_ADDIU) ? OP_ADD : OP_SUB;
        d_alu_res_sel = (opcode == OPC_ADDIU) ? RES_ALU : RES_SET;
        d_alu_set_u   = (opcode == OPC_SLTIU);
      end
      OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
        d_dest_reg  = rt;
        d_imm       = {{(data_width-16){1'b0}}, imm16};
        d_imm_valid = 1'b1;
        case (opcode)
          OPC_ANDI: d_alu_op = OP_AND;
          OPC_ORI:  d_alu_op = OP_OR;
          OPC_XORI: d_alu_op = OP_XOR;
          default:  d_alu_op = OP_LUI;
        endcase
      end
      OPC_SPECIAL3: begin
        d_dest_reg = rt;
        d_imm      = {{(data_width-16){1'b0}}, imm16}; // Raw msb and lsb fields.
        case (funct)
          FN_EXT: begin
            d_shopsela = 1'b1;
            d_alu_op   = OP_EXT;
          end
          FN_INS: begin
            d_shopsela = 1'b1;
            d_shleft   = 1'b1;
            d_alu_op   = OP_INS;
          end
          FN_BSHFL: begin
            d_dest_reg = rd;
            if (sa == 5'h10) begin
              d_alu_op = OP_SEB;
            end else if (sa == 5'h18) begin
              d_alu_op = OP_SEH;
            end else begin
              legal = 1'b0;
            end
          end
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    // Unsupported words pass a zero immediate through.
    if (!legal) begin
      d_imm         = '0;
      d_imm_valid   = 1'b1;
      d_alu_op      = OP_PASS_B;
      d_alu_res_sel = RES_ALU;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid      <= 1'b0;
      ex_dest_valid <= 1'b0;
      ex_dest_reg   <= '0;
      imm_valid     <= 1'b0;
      shamt_valid   <= 1'b0;
      shleft        <= 1'b0;
      sharith       <= 1'b0;
      shopsela      <= 1'b0;
      alu_op        <= OP_ADD;
      alu_res_sel   <= RES_ALU;
      alu_set_u     <= 1'b0;
    end else begin
      ex_valid <= instr_valid;
      if (instr_valid) begin
        ex_dest_valid <= legal && (d_dest_reg != '0);
        ex_dest_reg   <= d_dest_reg;
        imm_valid     <= d_imm_valid;
        shamt_valid   <= d_shamt_valid;
        shleft        <= d_shleft;
        sharith       <= d_sharith;
        shopsela      <= d_shopsela;
        alu_op        <= d_alu_op;
        alu_res_sel   <= d_alu_res_sel;
        alu_set_u     <= d_alu_set_u;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (instr_valid) begin
      a_val <= a_fwd;
      b_val <= b_fwd;
      imm   <= d_imm;
      shamt <= sa;
    end
  end

endmodule

//--- rtl/ex.sv
`timescale 1ns/100ps

module ex (
  input  logic [pip_types::data_width-1:0]          a_val,
  input  logic [pip_types::data_width-1:0]          b_val,
  input  logic [pip_types::data_width-1:0]          imm,
  input  logic                                      imm_valid,
  input  logic [$clog2(pip_types::data_width)-1:0]  shamt,
  input  logic                                      shamt_valid,
  input  logic                                      shleft,
  input  logic                                      sharith,
  input  logic                                      shopsela,
  input  pip_types::alu_op_t                        alu_op,
  input  pip_types::alu_res_t                       alu_res_sel,
  input  logic                                      alu_set_u,
  output logic [pip_types::data_width-1:0]          result,
  output logic                                      inval_dest_reg
);

  import pip_types::*;

  logic [data_width-1:0]         b_op;
  logic [$clog2(data_width)-1:0] shift_amt;
  logic [data_width-1:0]         shift_in;
  logic [data_width-1:0]         shift_res;
  logic [data_width-1:0]         diff;
  logic                          borrow;
  logic                          less;
  logic [4:0]                    fld_lsb;
  logic [4:0]                    fld_msb;
  logic [data_width-1:0]         low_mask;
  logic [data_width-1:0]         ins_mask;
  logic [data_width-1:0]         alu_res;

  assign b_op      = imm_valid ? imm : b_val;
  assign shift_amt = shamt_valid ? shamt : a_val[$clog2(data_width)-1:0];
  assign shift_in  = shopsela ? a_val : b_op;

  assign {borrow, diff} = {1'b0, a_val} - {1'b0, b_op}; // Borrow set when A < B unsigned.

  always_comb begin
    if (alu_set_u) begin
      less = borrow;
    end else if (a_val[data_width-1] != b_op[data_width-1]) begin
      less = a_val[data_width-1]; // Signs differ, the negative one is smaller.
    end else begin
      less = diff[data_width-1];
    end
  end

  // Field masks for EXT and INS. msb field is size-1 for EXT, msb for INS.
  assign fld_lsb  = imm[10:6];
  assign fld_msb  = imm[15:11];
  assign low_mask = {data_width{1'b1}} >> (5'd31 - fld_msb);
  assign ins_mask = low_mask & ({data_width{1'b1}} << fld_lsb);

  always_comb begin
    case (alu_op)
      OP_ADD:    alu_res = a_val + b_op;
      OP_SUB:    alu_res = diff;
      OP_OR:     alu_res = a_val | b_op;
      OP_XOR:    alu_res = a_val ^ b_op;
      OP_NOR:    alu_res = ~(a_val | b_op);
      OP_AND:    alu_res = a_val & b_op;
      OP_PASS_A: alu_res = a_val;
      OP_PASS_B: alu_res = b_op;
      OP_LUI:    alu_res = b_op << 16;
      OP_MOVZ:   alu_res = a_val;
      OP_MOVN:   alu_res = a_val;
      OP_SEB:    alu_res = {{(data_width-8){b_op[7]}}, b_op[7:0]};
      OP_SEH:    alu_res = {{(data_width-16){b_op[15]}}, b_op[15:0]};
      OP_EXT:    alu_res = shift_res & low_mask; // rs >> lsb, size bits kept.
      OP_INS:    alu_res = (shift_res & ins_mask) | (b_val & ~ins_mask); // Merge into rt.
      default:   alu_res = '0;
    endcase
  end

  always_comb begin
    case (alu_res_sel)
      RES_SHIFT: result = shift_res;
      RES_SET:   result = {{(data_width-1){1'b0}}, less};
      default:   result = alu_res;
    endcase
  end

  // MOVZ writes only on rt zero, MOVN only on rt nonzero.
  assign inval_dest_reg = (alu_op == OP_MOVZ) ? (b_val != '0) :
                          (alu_op == OP_MOVN) ? (b_val == '0) : 1'b0;

  shifter #(
    .data_width  (data_width),
    .shamt_width ($clog2(data_width))
  ) u_shifter (
    .din     (shift_in),
    .shamt   (shift_amt),
    .shleft  (shleft),
    .sharith (sharith),
    .dout    (shift_res)
  );

  chk_res_sel: assert final (!$isunknown(alu_res_sel))
    else $error("ex: result select is unknown");

endmodule

//--- rtl/shifter.sv
`timescale 1ns/100ps

module shifter #(
  parameter int data_width  = 32,
  parameter int shamt_width = 5
) (
  input  logic [data_width-1:0]  din,
  input  logic [shamt_width-1:0] shamt,
  input  logic                   shleft,
  input  logic                   sharith,
  output logic [data_width-1:0]  dout
);

  logic [data_width-1:0] rev_in;
  logic [data_width-1:0] rev_out;
  logic [data_width-1:0] stage [shamt_width+1];
  logic                  fill;

  // Left shifts run through the right shifter on a bit-reversed word.
  always_comb begin
    for (int i = 0; i < data_width; i++) begin
      rev_in[i]  = din[data_width-1-i];
      rev_out[i] = stage[shamt_width][data_width-1-i];
    end
  end

  assign fill     = sharith & ~shleft & din[data_width-1]; // Sign fill for SRA.
  assign stage[0] = shleft ? rev_in : din;

  for (genvar s = 0; s < shamt_width; s++) begin : g_stage
    assign stage[s+1] = shamt[s] ? {{(2**s){fill}}, stage[s][data_width-1:2**s]}
                                 : stage[s];
  end

  assign dout = shleft ? rev_out : stage[shamt_width];

  chk_dir: assert final (!(shleft && sharith))
    else $error("shifter: left and arithmetic shift requested together");

endmodule

//--- rtl/pip_types.sv
package pip_types;

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;

  // Major opcodes, instr[31:26].
  typedef enum logic [5:0] {
    OPC_SPECIAL  = 6'h00,
    OPC_ADDIU    = 6'h09,
    OPC_SLTI     = 6'h0a,
    OPC_SLTIU    = 6'h0b,
    OPC_ANDI     = 6'h0c,
    OPC_ORI      = 6'h0d,
    OPC_XORI     = 6'h0e,
    OPC_LUI      = 6'h0f,
    OPC_SPECIAL3 = 6'h1f
  } opcode_t;

  // Function codes, instr[5:0]. SPECIAL shifts (0..7) are decoded as a group,
  // so the SPECIAL3 codes EXT and INS can share their values here.
  typedef enum logic [5:0] {
    FN_EXT   = 6'h00,
    FN_INS   = 6'h04,
    FN_MOVZ  = 6'h0a,
    FN_MOVN  = 6'h0b,
    FN_BSHFL = 6'h20,
    FN_ADDU  = 6'h21,
    FN_SUBU  = 6'h23,
    FN_AND   = 6'h24,
    FN_OR    = 6'h25,
    FN_XOR   = 6'h26,
    FN_NOR   = 6'h27,
    FN_SLT   = 6'h2a,
    FN_SLTU  = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_AND,
    OP_PASS_A,
    OP_PASS_B,
    OP_LUI,
    OP_MOVZ,
    OP_MOVN,
    OP_SEB,
    OP_SEH,
    OP_EXT,
    OP_INS
  } alu_op_t;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_SHIFT,
    RES_SET
  } alu_res_t;

endpackage
